/* bench/tb_wb_stage.sv */
`timescale 1ns/10ps

module tb_wb_stage;
    import wb_pkg::*;

    localparam int N_GROUPS = 35;

    logic clk = 1'b0;
    logic aresetn;
    logic lane_valid_0, lane_valid_1;
    op_class_t lane_op_0, lane_op_1;
    logic [4:0] lane_rd_0, lane_rd_1, dcache_rd, wb_rd0, wb_rd1, wb_rd2;
    logic [31:0] lane_result_0, lane_result_1, badv_in, era_in, quotient, remainder;
    logic [31:0] csr_rdata, dcache_data, eentry, tlbrentry, csr_era;
    logic [31:0] wb_data0, wb_data1, wb_data2, badv_out, era_out, redirect_pc;
    logic [5:0] ecode_in, ecode_out;
    logic [18:0] vppn_out;
    logic exc_valid_in, interrupt, ertn_in, div_ready, csr_ready, dcache_ready;
    logic wb_we0, wb_we1, wb_we2, exc_flag, wen_badv, wen_vppn, wen_era, tlb_refill;
    logic allowin, redirect_valid;

    logic [31:0] seed = 32'h8d88255a;
    logic [36:0] q0[$];
    logic [36:0] q1[$];
    logic [36:0] q2[$];
    logic [4:0]  ld_q[$];
    logic [36:0] e0, e1, e2;
    logic [5:0]  exc_codes [10];
    int err_cnt = 0;
    int total;

    wb_stage_top dut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    function automatic logic writes_port(input op_class_t op, input logic has_csr);
        return (op inside {OP_ALU, OP_LINK, OP_DIV_QUO, OP_DIV_REM})
            || (has_csr && op == OP_CSR);
    endfunction

    function automatic logic [31:0] expected_data(input op_class_t op, input logic [31:0] res);
        case (op)
            OP_LINK:    return res + 32'd4;
            OP_DIV_QUO: return quotient;
            OP_DIV_REM: return remainder;
            OP_CSR:     return csr_rdata;
            default:    return res;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            err_cnt++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // cache returns pending loads in order at random
    task automatic cache_model();
        logic [31:0] d;
        dcache_ready = 1'b0;
        if (ld_q.size() > 0 && next_rand() % 4 == 0) begin
            d = next_rand();
            dcache_ready = 1'b1;
            dcache_rd = ld_q.pop_front();
            dcache_data = d;
            q2.push_back({dcache_rd, d});
        end
    endtask

    task automatic idle_cycle();
        cache_model();
        @(posedge clk);
        #1;
        dcache_ready = 1'b0;
    endtask

    task automatic run_group(input logic v0, input op_class_t op0, input logic v1,
                             input op_class_t op1, input logic exc, input logic [5:0] code,
                             input logic intr, input logic ertn);
        logic [31:0] r;
        logic need_div;
        logic need_csr;
        logic acc;
        int div_wait;
        int csr_wait;
        r = next_rand();
        lane_rd_0 = r[4:0];
        lane_rd_1 = r[12:8];
        lane_valid_0 = v0;
        lane_op_0 = op0;
        lane_valid_1 = v1;
        lane_op_1 = op1;
        lane_result_0 = next_rand();
        lane_result_1 = next_rand();
        exc_valid_in = exc;
        ecode_in = code;
        interrupt = intr;
        ertn_in = ertn;
        badv_in = next_rand();
        era_in = next_rand();
        quotient = next_rand();
        remainder = next_rand();
        csr_rdata = next_rand();
        need_div = (v0 && (op0 == OP_DIV_QUO || op0 == OP_DIV_REM))
                || (v1 && (op1 == OP_DIV_QUO || op1 == OP_DIV_REM));
        need_csr = (v0 && op0 == OP_CSR) || (v1 && op1 == OP_CSR);
        div_wait = int'(next_rand() % 6) + 1;
        csr_wait = int'(next_rand() % 6) + 1;
        acc = 1'b0;
        while (!acc) begin
            div_ready = need_div && div_wait == 0;
            csr_ready = need_csr && csr_wait == 0;
            cache_model();
            @(negedge clk);
            acc = allowin;
            if (!acc) begin
                @(posedge clk);
                #1;
                if (div_wait > 0) begin
                    div_wait--;
                end
                if (csr_wait > 0) begin
                    csr_wait--;
                end
            end
        end
        if (!exc && !intr) begin
            if (v0 && writes_port(op0, 1'b1))
                q0.push_back({lane_rd_0, expected_data(op0, lane_result_0)});
            if (v1 && writes_port(op1, 1'b0))
                q1.push_back({lane_rd_1, expected_data(op1, lane_result_1)});
            if (v0 && op0 == OP_LOAD)
                ld_q.push_back(lane_rd_0);
            else if (v1 && op1 == OP_LOAD)
                ld_q.push_back(lane_rd_1);
        end
        @(posedge clk);
        #1;
        lane_valid_0 = 1'b0;
        lane_valid_1 = 1'b0;
        exc_valid_in = 1'b0;
        interrupt = 1'b0;
        ertn_in = 1'b0;
        div_ready = 1'b0;
        csr_ready = 1'b0;
        dcache_ready = 1'b0;
    endtask

    always @(negedge clk) begin
        if (aresetn && wb_we0) begin
            if (q0.size() == 0) begin
                err_cnt++;
                $display("unexpected write on port 0 at %0t", $time);
            end else begin
                e0 = q0.pop_front();
                compare("wb_rd0", {27'd0, e0[36:32]}, {27'd0, wb_rd0});
                compare("wb_data0", e0[31:0], wb_data0);
            end
        end
        if (aresetn && wb_we1) begin
            if (q1.size() == 0) begin
                err_cnt++;
                $display("unexpected write on port 1 at %0t", $time);
            end else begin
                e1 = q1.pop_front();
                compare("wb_rd1", {27'd0, e1[36:32]}, {27'd0, wb_rd1});
                compare("wb_data1", e1[31:0], wb_data1);
            end
        end
        if (aresetn && wb_we2) begin
            if (q2.size() == 0) begin
                err_cnt++;
                $display("unexpected write on port 2 at %0t", $time);
            end else begin
                e2 = q2.pop_front();
                compare("wb_rd2", {27'd0, e2[36:32]}, {27'd0, wb_rd2});
                compare("wb_data2", e2[31:0], wb_data2);
            end
        end
    end

    // watchdog
    initial begin
        #((N_GROUPS * 10 + 200) * 20);
        $display("watchdog timeout, the groups did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        aresetn = 1'b0;
        lane_valid_0 = 1'b0;
        lane_valid_1 = 1'b0;
        lane_op_0 = OP_NONE;
        lane_op_1 = OP_NONE;
        lane_rd_0 = '0;
        lane_rd_1 = '0;
        lane_result_0 = '0;
        lane_result_1 = '0;
        exc_valid_in = 1'b0;
        ecode_in = '0;
        badv_in = '0;
        era_in = '0;
        interrupt = 1'b0;
        ertn_in = 1'b0;
        quotient = '0;
        remainder = '0;
        div_ready = 1'b0;
        csr_rdata = '0;
        csr_ready = 1'b0;
        dcache_ready = 1'b0;
        dcache_data = '0;
        dcache_rd = '0;
        eentry = 32'h1c00_8000;
        tlbrentry = 32'h1c00_f000;
        csr_era = 32'h1c00_4444;
        exc_codes = '{ECODE_PIL, ECODE_PIS, ECODE_PIF, ECODE_PME, ECODE_PPI,
                      ECODE_ADEF, ECODE_ALE, ECODE_TLBR, ECODE_SYS, ECODE_INT};
        repeat (4) @(posedge clk);
        #1;
        aresetn = 1'b1;
        idle_cycle();

        for (int i = 0; i < 8; i++) begin
            run_group(1'b1, (i % 2 == 0) ? OP_ALU : OP_LINK, 1'b1,
                      (i % 3 == 0) ? OP_LINK : OP_ALU, 1'b0, '0, 1'b0, 1'b0);
        end
        run_group(1'b1, OP_DIV_QUO, 1'b1, OP_ALU, 1'b0, '0, 1'b0, 1'b0);
        run_group(1'b1, OP_DIV_REM, 1'b0, OP_NONE, 1'b0, '0, 1'b0, 1'b0);
        run_group(1'b1, OP_ALU, 1'b1, OP_DIV_QUO, 1'b0, '0, 1'b0, 1'b0);
        run_group(1'b0, OP_NONE, 1'b1, OP_DIV_REM, 1'b0, '0, 1'b0, 1'b0);
        run_group(1'b1, OP_LINK, 1'b1, OP_DIV_REM, 1'b0, '0, 1'b0, 1'b0);
        run_group(1'b1, OP_CSR, 1'b1, OP_ALU, 1'b0, '0, 1'b0, 1'b0);
        run_group(1'b1, OP_CSR, 1'b0, OP_NONE, 1'b0, '0, 1'b0, 1'b0);
        // lane 1 has no csr path, so its port stays idle
        run_group(1'b1, OP_ALU, 1'b1, OP_CSR, 1'b0, '0, 1'b0, 1'b0);

        // loads faster than the cache returns them
        for (int i = 0; i < 6; i++) begin
            run_group(1'b1, OP_LOAD, 1'b1, OP_ALU, 1'b0, '0, 1'b0, 1'b0);
        end
        while (ld_q.size() > 0) begin
            idle_cycle();
        end
        repeat (2) idle_cycle();

        foreach (exc_codes[i]) begin
            run_group(1'b1, OP_ALU, 1'b1, OP_LINK, 1'b1, exc_codes[i], 1'b0, 1'b0);
        end
        run_group(1'b1, OP_ALU, 1'b1, OP_ALU, 1'b0, ECODE_SYS, 1'b1, 1'b0);
        run_group(1'b0, OP_NONE, 1'b0, OP_NONE, 1'b0, '0, 1'b0, 1'b1);
        run_group(1'b1, OP_ALU, 1'b1, OP_ALU, 1'b0, '0, 1'b0, 1'b0);
        repeat (4) idle_cycle();

        if (q0.size() + q1.size() + q2.size() != 0) begin
            err_cnt++;
            $display("expected writes never appeared on the write ports");
        end
        total = err_cnt + dut.u_check.fail_cnt;
        $display("errors: bench %0d, assertions %0d", err_cnt, dut.u_check.fail_cnt);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* bench/wb_stage_checker.sv */
`timescale 1ns/10ps

module wb_stage_checker (
    input logic                          clk,
    input logic                          aresetn,
    input logic                          lane_valid_0,
    input wb_pkg::op_class_t             lane_op_0,
    input logic [wb_pkg::REG_ADDR_W-1:0] lane_rd_0,
    input logic                          lane_valid_1,
    input wb_pkg::op_class_t             lane_op_1,
    input logic [wb_pkg::REG_ADDR_W-1:0] lane_rd_1,
    input logic                          exc_valid_in,
    input logic [wb_pkg::ECODE_W-1:0]    ecode_in,
    input logic [wb_pkg::XLEN-1:0]       badv_in,
    input logic [wb_pkg::XLEN-1:0]       era_in,
    input logic                          interrupt,
    input logic                          ertn_in,
    input logic                          div_ready,
    input logic                          csr_ready,
    input logic                          dcache_ready,
    input logic [wb_pkg::XLEN-1:0]       dcache_data,
    input logic [wb_pkg::REG_ADDR_W-1:0] dcache_rd,
    input logic [wb_pkg::XLEN-1:0]       eentry,
    input logic [wb_pkg::XLEN-1:0]       tlbrentry,
    input logic [wb_pkg::XLEN-1:0]       csr_era,
    input logic                          wb_we0,
    input logic [wb_pkg::REG_ADDR_W-1:0] wb_rd0,
    input logic                          wb_we1,
    input logic [wb_pkg::REG_ADDR_W-1:0] wb_rd1,
    input logic                          wb_we2,
    input logic [wb_pkg::REG_ADDR_W-1:0] wb_rd2,
    input logic [wb_pkg::XLEN-1:0]       wb_data2,
    input logic                          exc_flag,
    input logic [wb_pkg::ECODE_W-1:0]    ecode_out,
    input logic [wb_pkg::XLEN-1:0]       badv_out,
    input logic                          wen_badv,
    input logic [wb_pkg::VPPN_W-1:0]     vppn_out,
    input logic                          wen_vppn,
    input logic [wb_pkg::XLEN-1:0]       era_out,
    input logic                          wen_era,
    input logic                          tlb_refill,
    input logic                          allowin,
    input logic                          redirect_valid,
    input logic [wb_pkg::XLEN-1:0]       redirect_pc
);
    import wb_pkg::*;

    int fail_cnt = 0;
    logic [1:0] loads_out;
    logic exc_now, ld_acc, quiet, exp_vppn, exp_badv, exp_tlbr;

    assign exc_now = exc_valid_in || interrupt;
    assign ld_acc = allowin && !exc_now && ((lane_valid_0 && lane_op_0 == OP_LOAD)
                 || (lane_valid_1 && lane_op_1 == OP_LOAD));
    assign quiet = !(wb_we0 || wb_we1 || wb_we2 || exc_flag || wen_badv || wen_vppn
                  || wen_era || tlb_refill || redirect_valid);
    assign exp_vppn = !interrupt && (ecode_in inside {ECODE_PIL, ECODE_PIS, ECODE_PIF,
                                                      ECODE_PME, ECODE_PPI, ECODE_TLBR});
    assign exp_badv = exp_vppn || (!interrupt && (ecode_in inside {ECODE_ADEF, ECODE_ALE}));
    assign exp_tlbr = !interrupt && ecode_in == ECODE_TLBR;

    // loads issued and not yet returned
    always_ff @(posedge clk) begin
        if (!aresetn || (allowin && exc_now)) begin
            loads_out <= 2'd0;
        end else if (ld_acc && !dcache_ready) begin
            loads_out <= loads_out + 2'd1;
        end else if (dcache_ready && !ld_acc && loads_out != 2'd0) begin
            loads_out <= loads_out - 2'd1;
        end
    end

    assert property (@(posedge clk) !aresetn |=> quiet && allowin)
        else begin
            fail_cnt++;
            $error("outputs active during or right after reset");
        end

    assert property (@(posedge clk) disable iff (!aresetn)
        allowin && lane_valid_0 && !exc_now && (lane_op_0 inside {OP_ALU, OP_LINK,
        OP_DIV_QUO, OP_DIV_REM, OP_CSR}) |=> wb_we0 && wb_rd0 == $past(lane_rd_0))
        else begin
            fail_cnt++;
            $error("lane 0 write missing one cycle after accept");
        end

    assert property (@(posedge clk) disable iff (!aresetn)
        allowin && lane_valid_1 && !exc_now && (lane_op_1 inside {OP_ALU, OP_LINK,
        OP_DIV_QUO, OP_DIV_REM}) |=> wb_we1 && wb_rd1 == $past(lane_rd_1))
        else begin
            fail_cnt++;
            $error("lane 1 write missing one cycle after accept");
        end

    assert property (@(posedge clk) disable iff (!aresetn)
        ((lane_valid_0 && lane_op_0 inside {OP_DIV_QUO, OP_DIV_REM})
        || (lane_valid_1 && lane_op_1 inside {OP_DIV_QUO, OP_DIV_REM})) && !div_ready
        |-> !allowin)
        else begin
            fail_cnt++;
            $error("divide group accepted before div_ready");
        end

    assert property (@(posedge clk) disable iff (!aresetn)
        lane_valid_0 && lane_op_0 == OP_CSR && !csr_ready |-> !allowin)
        else begin
            fail_cnt++;
            $error("csr group accepted before csr_ready");
        end

    assert property (@(posedge clk) disable iff (!aresetn)
        loads_out == 2'd2 && !dcache_ready |-> !allowin)
        else begin
            fail_cnt++;
            $error("group accepted with two loads outstanding");
        end

    assert property (@(posedge clk) disable iff (!aresetn)
        dcache_ready |=> wb_we2 && wb_rd2 == $past(dcache_rd)
        && wb_data2 == $past(dcache_data))
        else begin
            fail_cnt++;
            $error("load return not written on port 2");
        end

    assert property (@(posedge clk) disable iff (!aresetn)
        allowin && exc_now |=> exc_flag && wen_era && !wb_we0 && !wb_we1
        && wen_badv == $past(exp_badv) && wen_vppn == $past(exp_vppn)
        && tlb_refill == $past(exp_tlbr) && redirect_valid
        && redirect_pc == ($past(exp_tlbr) ? tlbrentry : eentry))
        else begin
            fail_cnt++;
            $error("exception strobes or redirect wrong");
        end

    // captured code, bad address, page number and return address
    assert property (@(posedge clk) disable iff (!aresetn)
        allowin && exc_now |=> ecode_out == ($past(interrupt) ? ECODE_INT : $past(ecode_in))
        && badv_out == $past(badv_in) && era_out == $past(era_in)
        && vppn_out == $past(badv_in[XLEN-1:XLEN-VPPN_W]))
        else begin
            fail_cnt++;
            $error("exception csr values not captured from the accepted group");
        end

    assert property (@(posedge clk) disable iff (!aresetn)
        allowin && ertn_in && !exc_now |=> redirect_valid && redirect_pc == csr_era)
        else begin
            fail_cnt++;
            $error("ertn did not redirect to csr_era");
        end

endmodule

bind wb_stage_top wb_stage_checker u_check (.*);

/* filelist.f */
rtl/wb_pkg.sv
rtl/wb_lane_select.sv
rtl/load_tracker.sv
rtl/stall_ctrl.sv
rtl/exc_commit.sv
rtl/wb_stage_top.sv
bench/wb_stage_checker.sv
bench/tb_wb_stage.sv

/* rtl/exc_commit.sv */
`timescale 1ns/10ps

module exc_commit (
    input  logic                       clk,
    input  logic                       aresetn,
    input  logic                       accept,
    input  logic                       exc_valid_in,
    input  logic [wb_pkg::ECODE_W-1:0] ecode_in,
    input  logic [wb_pkg::XLEN-1:0]    badv_in,
    input  logic [wb_pkg::XLEN-1:0]    era_in,
    input  logic                       interrupt,
    input  logic                       ertn_in,
    input  logic [wb_pkg::XLEN-1:0]    eentry,
    input  logic [wb_pkg::XLEN-1:0]    tlbrentry,
    input  logic [wb_pkg::XLEN-1:0]    csr_era,
    output logic                       squash,
    output logic                       exc_flag,
    output logic [wb_pkg::ECODE_W-1:0] ecode_out,
    output logic [wb_pkg::XLEN-1:0]    badv_out,
    output logic                       wen_badv,
    output logic [wb_pkg::VPPN_W-1:0]  vppn_out,
    output logic                       wen_vppn,
    output logic [wb_pkg::XLEN-1:0]    era_out,
    output logic                       wen_era,
    output logic                       tlb_refill,
    output logic                       redirect_valid,
    output logic [wb_pkg::XLEN-1:0]    redirect_pc
);
    import wb_pkg::*;

    logic [ECODE_W-1:0] code_sel;
    logic               tlb_code;
    logic               addr_code;
    logic               ertn_q;

    // interrupt wins over a synchronous exception in the same group
    assign code_sel = interrupt ? ECODE_INT : ecode_in;

    assign tlb_code = (code_sel == ECODE_PIL) || (code_sel == ECODE_PIS)
                   || (code_sel == ECODE_PIF) || (code_sel == ECODE_PME)
                   || (code_sel == ECODE_PPI) || (code_sel == ECODE_TLBR);
    assign addr_code = tlb_code || (code_sel == ECODE_ADEF) || (code_sel == ECODE_ALE);

    assign squash = accept && (exc_valid_in || interrupt);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            exc_flag   <= 1'b0;
            wen_badv   <= 1'b0;
            wen_vppn   <= 1'b0;
            wen_era    <= 1'b0;
            tlb_refill <= 1'b0;
            ertn_q     <= 1'b0;
        end else begin
            exc_flag   <= squash;
            wen_badv   <= squash && addr_code;
            wen_vppn   <= squash && tlb_code;
            wen_era    <= squash;
            tlb_refill <= squash && (code_sel == ECODE_TLBR);
            ertn_q     <= accept && ertn_in && !squash;
        end
    end

    always_ff @(posedge clk) begin
        if (squash) begin
            ecode_out <= code_sel;
            badv_out  <= badv_in;
            vppn_out  <= badv_in[XLEN-1 -: VPPN_W];
            era_out   <= era_in;
        end
    end

    assign redirect_valid = exc_flag || ertn_q;
    assign redirect_pc    = tlb_refill ? tlbrentry :
                            exc_flag   ? eentry    : csr_era;

endmodule

/* rtl/load_tracker.sv */
`timescale 1ns/10ps

module load_tracker (
    input  logic                          clk,
    input  logic                          aresetn,
    input  logic                          load_accept,
    input  logic                          dcache_ready,
    input  logic [wb_pkg::XLEN-1:0]       dcache_data,
    input  logic [wb_pkg::REG_ADDR_W-1:0] dcache_rd,
    input  logic                          squash,
    output logic                          loads_full,
    output logic                          wb_we2,
    output logic [wb_pkg::REG_ADDR_W-1:0] wb_rd2,
    output logic [wb_pkg::XLEN-1:0]       wb_data2
);
    import wb_pkg::*;

    logic [LOAD_CNT_W-1:0] load_cnt;

    // a return this cycle frees a slot for the next group
    assign loads_full = (load_cnt == LOAD_CNT_W'(MAX_LOADS)) && !dcache_ready;

    always_ff @(posedge clk) begin
        if (!aresetn || squash) begin
            load_cnt <= '0;
        end else if (load_accept && !dcache_ready) begin
            if (load_cnt != LOAD_CNT_W'(MAX_LOADS)) begin
                load_cnt <= load_cnt + 1'b1;
            end
        end else if (dcache_ready && !load_accept) begin
            if (load_cnt != '0) begin
                load_cnt <= load_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            wb_we2 <= 1'b0;
        end else begin
            wb_we2 <= dcache_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (dcache_ready) begin
            wb_rd2   <= dcache_rd;
            wb_data2 <= dcache_data;
        end
    end

endmodule

/* rtl/stall_ctrl.sv */
`timescale 1ns/10ps

module stall_ctrl (
    input  logic              clk,
    input  logic              aresetn,
    input  logic              lane_valid_0,
    input  logic              lane_valid_1,
    input  wb_pkg::op_class_t lane_op_0,
    input  wb_pkg::op_class_t lane_op_1,
    input  logic              div_ready,
    input  logic              csr_ready,
    input  logic              loads_full,
    output logic              allowin,
    output logic              load_accept
);
    import wb_pkg::*;

    typedef enum logic [1:0] {
        RUN      = 2'd0,
        DIV_WAIT = 2'd1,
        CSR_WAIT = 2'd2
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   need_div;
    logic   need_csr;
    logic   has_load;
    logic   div_blk;
    logic   csr_blk;

    assign need_div = (lane_valid_0 && (lane_op_0 == OP_DIV_QUO || lane_op_0 == OP_DIV_REM))
                   || (lane_valid_1 && (lane_op_1 == OP_DIV_QUO || lane_op_1 == OP_DIV_REM));
    assign need_csr = (lane_valid_0 && lane_op_0 == OP_CSR)
                   || (lane_valid_1 && lane_op_1 == OP_CSR);
    assign has_load = (lane_valid_0 && lane_op_0 == OP_LOAD)
                   || (lane_valid_1 && lane_op_1 == OP_LOAD);

    assign div_blk = need_div && !div_ready;
    assign csr_blk = need_csr && !csr_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            RUN: begin
                allowin = !div_blk && !csr_blk && !loads_full;
                if (div_blk) begin
                    state_nxt = DIV_WAIT;
                end else if (csr_blk) begin
                    state_nxt = CSR_WAIT;
                end
            end
            // group is held steady, only the strobe is awaited
            DIV_WAIT: begin
                allowin = div_ready && !loads_full;
                if (allowin) begin
                    state_nxt = RUN;
                end
            end
            CSR_WAIT: begin
                allowin = csr_ready && !loads_full;
                if (allowin) begin
                    state_nxt = RUN;
                end
            end
            default: begin
                allowin   = 1'b0;
                state_nxt = RUN;
            end
        endcase
    end

    assign load_accept = allowin && has_load;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= RUN;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

/* rtl/wb_lane_select.sv */
`timescale 1ns/10ps

module wb_lane_select #(
    parameter int HAS_CSR = 1
) (
    input  logic                          clk,
    input  logic                          aresetn,
    input  logic                          lane_valid,
    input  wb_pkg::op_class_t             lane_op,
    input  logic [wb_pkg::REG_ADDR_W-1:0] lane_rd,
    input  logic [wb_pkg::XLEN-1:0]       lane_result,
    input  logic [wb_pkg::XLEN-1:0]       quotient,
    input  logic [wb_pkg::XLEN-1:0]       remainder,
    input  logic [wb_pkg::XLEN-1:0]       csr_rdata,
    input  logic                          accept,
    input  logic                          squash,
    output logic                          wb_we,
    output logic [wb_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [wb_pkg::XLEN-1:0]       wb_data
);
    import wb_pkg::*;

    logic            sel_we;
    logic [XLEN-1:0] sel_data;
    logic            do_write;

    always_comb begin
        sel_we   = 1'b0;
        sel_data = lane_result;
        case (lane_op)
            OP_ALU: begin
                sel_we = 1'b1;
            end
            OP_LINK: begin
                sel_we   = 1'b1;
                sel_data = lane_result + LINK_OFFSET;
            end
            OP_DIV_QUO: begin
                sel_we   = 1'b1;
                sel_data = quotient;
            end
            OP_DIV_REM: begin
                sel_we   = 1'b1;
                sel_data = remainder;
            end
            OP_CSR: begin
                // only lane 0 talks to the csr unit
                sel_we   = (HAS_CSR != 0);
                sel_data = csr_rdata;
            end
            default: begin
                sel_we = 1'b0;
            end
        endcase
    end

    assign do_write = accept & lane_valid & ~squash & sel_we;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            wb_we <= 1'b0;
        end else begin
            wb_we <= do_write;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            wb_rd   <= lane_rd;
            wb_data <= sel_data;
        end
    end

endmodule

/* rtl/wb_pkg.sv */
package wb_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ECODE_W    = 6;
    localparam int VPPN_W     = 19;

    // outstanding loads allowed between issue and cache return
    localparam int MAX_LOADS  = 2;
    localparam int LOAD_CNT_W = $clog2(MAX_LOADS + 1);

    // link writes the return address, pc of the branch plus one word
    localparam logic [XLEN-1:0] LINK_OFFSET = 32'd4;

    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_ALU     = 3'd1,
        OP_LINK    = 3'd2,
        OP_DIV_QUO = 3'd3,
        OP_DIV_REM = 3'd4,
        OP_CSR     = 3'd5,
        OP_LOAD    = 3'd6
    } op_class_t;

    // exception codes
    localparam logic [ECODE_W-1:0] ECODE_INT  = 6'h00;
    localparam logic [ECODE_W-1:0] ECODE_PIL  = 6'h01;
    localparam logic [ECODE_W-1:0] ECODE_PIS  = 6'h02;
    localparam logic [ECODE_W-1:0] ECODE_PIF  = 6'h03;
    localparam logic [ECODE_W-1:0] ECODE_PME  = 6'h04;
    localparam logic [ECODE_W-1:0] ECODE_PPI  = 6'h07;
    localparam logic [ECODE_W-1:0] ECODE_ADEF = 6'h08;
    localparam logic [ECODE_W-1:0] ECODE_ALE  = 6'h09;
    localparam logic [ECODE_W-1:0] ECODE_SYS  = 6'h0b;
    localparam logic [ECODE_W-1:0] ECODE_TLBR = 6'h3f;

endpackage

/* rtl/wb_stage_top.sv */
`timescale 1ns/10ps

module wb_stage_top (
    input  logic                          clk,
    input  logic                          aresetn,
    input  logic                          lane_valid_0,
    input  wb_pkg::op_class_t             lane_op_0,
    input  logic [wb_pkg::REG_ADDR_W-1:0] lane_rd_0,
    input  logic [wb_pkg::XLEN-1:0]       lane_result_0,
    input  logic                          lane_valid_1,
    input  wb_pkg::op_class_t             lane_op_1,
    input  logic [wb_pkg::REG_ADDR_W-1:0] lane_rd_1,
    input  logic [wb_pkg::XLEN-1:0]       lane_result_1,
    input  logic                          exc_valid_in,
    input  logic [wb_pkg::ECODE_W-1:0]    ecode_in,
    input  logic [wb_pkg::XLEN-1:0]       badv_in,
    input  logic [wb_pkg::XLEN-1:0]       era_in,
    input  logic                          interrupt,
    input  logic                          ertn_in,
    input  logic [wb_pkg::XLEN-1:0]       quotient,
    input  logic [wb_pkg::XLEN-1:0]       remainder,
    input  logic                          div_ready,
    input  logic [wb_pkg::XLEN-1:0]       csr_rdata,
    input  logic                          csr_ready,
    input  logic                          dcache_ready,
    input  logic [wb_pkg::XLEN-1:0]       dcache_data,
    input  logic [wb_pkg::REG_ADDR_W-1:0] dcache_rd,
    input  logic [wb_pkg::XLEN-1:0]       eentry,
    input  logic [wb_pkg::XLEN-1:0]       tlbrentry,
    input  logic [wb_pkg::XLEN-1:0]       csr_era,
    output logic                          wb_we0,
    output logic [wb_pkg::REG_ADDR_W-1:0] wb_rd0,
    output logic [wb_pkg::XLEN-1:0]       wb_data0,
    output logic                          wb_we1,
    output logic [wb_pkg::REG_ADDR_W-1:0] wb_rd1,
    output logic [wb_pkg::XLEN-1:0]       wb_data1,
    output logic                          wb_we2,
    output logic [wb_pkg::REG_ADDR_W-1:0] wb_rd2,
    output logic [wb_pkg::XLEN-1:0]       wb_data2,
    output logic                          exc_flag,
    output logic [wb_pkg::ECODE_W-1:0]    ecode_out,
    output logic [wb_pkg::XLEN-1:0]       badv_out,
    output logic                          wen_badv,
    output logic [wb_pkg::VPPN_W-1:0]     vppn_out,
    output logic                          wen_vppn,
    output logic [wb_pkg::XLEN-1:0]       era_out,
    output logic                          wen_era,
    output logic                          tlb_refill,
    output logic                          allowin,
    output logic                          redirect_valid,
    output logic [wb_pkg::XLEN-1:0]       redirect_pc
);

    logic squash;
    logic loads_full;
    logic load_accept;

    wb_lane_select #(.HAS_CSR(1)) lane0 (
        .clk(clk), .aresetn(aresetn), .lane_valid(lane_valid_0), .lane_op(lane_op_0),
        .lane_rd(lane_rd_0), .lane_result(lane_result_0), .quotient(quotient),
        .remainder(remainder), .csr_rdata(csr_rdata), .accept(allowin), .squash(squash),
        .wb_we(wb_we0), .wb_rd(wb_rd0), .wb_data(wb_data0)
    );

    wb_lane_select #(.HAS_CSR(0)) lane1 (
        .clk(clk), .aresetn(aresetn), .lane_valid(lane_valid_1), .lane_op(lane_op_1),
        .lane_rd(lane_rd_1), .lane_result(lane_result_1), .quotient(quotient),
        .remainder(remainder), .csr_rdata(csr_rdata), .accept(allowin), .squash(squash),
        .wb_we(wb_we1), .wb_rd(wb_rd1), .wb_data(wb_data1)
    );

    load_tracker u_load_tracker (
        .clk(clk), .aresetn(aresetn), .load_accept(load_accept),
        .dcache_ready(dcache_ready), .dcache_data(dcache_data), .dcache_rd(dcache_rd),
        .squash(squash), .loads_full(loads_full),
        .wb_we2(wb_we2), .wb_rd2(wb_rd2), .wb_data2(wb_data2)
    );

    stall_ctrl u_stall_ctrl (
        .clk(clk), .aresetn(aresetn), .lane_valid_0(lane_valid_0),
        .lane_valid_1(lane_valid_1), .lane_op_0(lane_op_0), .lane_op_1(lane_op_1),
        .div_ready(div_ready), .csr_ready(csr_ready), .loads_full(loads_full),
        .allowin(allowin), .load_accept(load_accept)
    );

    exc_commit u_exc_commit (
        .clk(clk), .aresetn(aresetn), .accept(allowin), .exc_valid_in(exc_valid_in),
        .ecode_in(ecode_in), .badv_in(badv_in), .era_in(era_in), .interrupt(interrupt),
        .ertn_in(ertn_in), .eentry(eentry), .tlbrentry(tlbrentry), .csr_era(csr_era),
        .squash(squash), .exc_flag(exc_flag), .ecode_out(ecode_out),
        .badv_out(badv_out), .wen_badv(wen_badv), .vppn_out(vppn_out),
        .wen_vppn(wen_vppn), .era_out(era_out), .wen_era(wen_era),
        .tlb_refill(tlb_refill), .redirect_valid(redirect_valid),
        .redirect_pc(redirect_pc)
    );

endmodule

/* run.sh */
#!/bin/sh
# build with Verilator and run; pass only if the pass message shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_wb_stage -f filelist.f -o sim_wb &&
./obj_dir/sim_wb | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "PASS" || { echo "FAIL"; exit 1; }
